// File: design/core_state_pkg.sv
`default_nettype none

package core_state_pkg;

  // sequencer state code as the core drives it
  typedef logic [5:0] core_state_t;

  // thread boundaries
  localparam core_state_t WAIT_FOR_START   = 6'h00;
  localparam core_state_t START_BEGIN      = 6'h01;
  localparam core_state_t FINISH_BEGIN     = 6'h02;
  localparam core_state_t FINISH_END       = 6'h03;
  // bus reads
  localparam core_state_t START_READ_CMD   = 6'h04;
  localparam core_state_t START_READ_CMD_P = 6'h05;
  localparam core_state_t READ_COND        = 6'h06;
  localparam core_state_t READ_COND_P      = 6'h07;
  localparam core_state_t READ_SRC1        = 6'h08;
  localparam core_state_t READ_SRC1_P      = 6'h09;
  localparam core_state_t READ_SRC0        = 6'h0a;
  localparam core_state_t READ_SRC0_P      = 6'h0b;
  localparam core_state_t READ_DST         = 6'h0c;
  // bus writes
  localparam core_state_t WRITE_REG_IP     = 6'h10;
  localparam core_state_t WRITE_DST        = 6'h11;
  localparam core_state_t WRITE_DST_P      = 6'h12;
  localparam core_state_t WRITE_SRC1       = 6'h13;
  localparam core_state_t WRITE_SRC0       = 6'h14;
  localparam core_state_t WRITE_COND       = 6'h15;
  // alu and beyond, not decoded here
  localparam core_state_t ALU_BEGIN        = 6'h20;

  // read group, READ_DST only counts for strobe gating
  function automatic logic is_read_state(input core_state_t s, input logic with_dst = 1'b1);
    case (s)
      START_READ_CMD, START_READ_CMD_P, READ_COND, READ_COND_P,
      READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P: return 1'b1;
      READ_DST: return with_dst;
      default: return 1'b0;
    endcase
  endfunction

  // write group
  function automatic logic is_write_state(input core_state_t s);
    case (s)
      WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0, WRITE_COND: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/cpu_msg_pkg.sv
`default_nettype none

package cpu_msg_pkg;

  // message code seen on the shared bus
  typedef logic [7:0] cpu_msg_t;

  // idle bus
  localparam cpu_msg_t MSG_NONE  = 8'h00;
  // core came out of reset
  localparam cpu_msg_t MSG_RESET = 8'h01;
  // thread started on sender
  localparam cpu_msg_t MSG_START = 8'h02;
  // thread ended on sender
  localparam cpu_msg_t MSG_END   = 8'h03;

  // cpu index word
  // raw view for equality and zero tests
  // split view for active flag and position
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      // bit 31
      logic        active;
      // bits 30..0
      logic [30:0] pos;
    } f;
  } cpu_index_u;

endpackage

`default_nettype wire

// File: design/reset_ctl_if.sv
`default_nettype none
`timescale 1ns/1ps

interface reset_ctl_if;

  // high once the post-reset steps are through
  logic seq_done;
  // step 3 strobe, index load
  logic capture_index;
  // step 1 strobe, drop online
  logic clear_online;
  // FINISH_END seen with no grant, rerun the steps
  logic finish_restart;
  // core was in FINISH_END at step 2
  logic was_finished;

  modport seq (output seq_done, capture_index, clear_online, was_finished,
               input finish_restart);
  modport tracker (input seq_done, capture_index, was_finished);
  modport ctl (input seq_done, capture_index, clear_online, output finish_restart);

endinterface

`default_nettype wire

// File: design/reset_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module reset_sequencer (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  core_state_pkg::core_state_t state,
  output logic                        rst,
  output logic                        ext_rst_e,
  output logic                        reset_msg,
  reset_ctl_if.seq                    ctl_if
);
  import core_state_pkg::*;

  // step numbers, counted in edges after bus reset
  localparam logic [2:0] STEP_CLEAR    = 3'd1;
  localparam logic [2:0] STEP_CHECK    = 3'd2;
  localparam logic [2:0] STEP_CAPTURE  = 3'd3;
  localparam logic [2:0] STEP_RESET    = 3'd4;
  localparam logic [2:0] STEP_DISPATCH = 3'd5;
  localparam logic [2:0] STEP_DONE     = 3'd6;

  logic [2:0] step;
  logic       finished_q;

  // strobes decoded from the step, acted on at the same edge
  assign ctl_if.clear_online  = (step == STEP_CLEAR);
  assign ctl_if.capture_index = (step == STEP_CAPTURE);
  assign ctl_if.seq_done      = (step == STEP_DONE);
  assign ctl_if.was_finished  = finished_q;

  // no reset message when rerun after FINISH_END
  assign reset_msg = (step == STEP_CAPTURE) && !finished_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step       <= STEP_CLEAR;
      finished_q <= 1'b0;
      rst        <= 1'b0;
      ext_rst_e  <= 1'b0;
    end else begin
      // core reset and echo only at step 4
      rst       <= (step == STEP_RESET);
      ext_rst_e <= (step == STEP_RESET) && !finished_q;

      // remember whether the core had already finished
      if (step == STEP_CHECK) begin
        finished_q <= (state == FINISH_END);
      end

      if (step == STEP_DONE) begin
        // parked until the core ends its thread
        if (ctl_if.finish_restart) begin
          step <= STEP_CLEAR;
        end
      end else if (step == STEP_DISPATCH) begin
        step <= STEP_DONE;
      end else begin
        step <= step + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/cpu_index_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_index_tracker (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  core_state_pkg::core_state_t state,
  input  logic                        ext_next_cpu_q,
  input  logic [31:0]                 ext_cpu_index,
  input  cpu_msg_pkg::cpu_msg_t       ext_cpu_msg_in,
  input  logic                        pass_token,
  output logic [1:0]                  ind_rel,
  output logic                        is_mine,
  reset_ctl_if.tracker                ctl_if
);
  import core_state_pkg::*;
  import cpu_msg_pkg::*;

  // own index and the token holder's index
  cpu_index_u my_idx;
  cpu_index_u holder;
  logic       same_idx;
  logic       holder_lower;
  logic       holder_higher;

  assign holder.raw    = ext_cpu_index;
  assign same_idx      = (holder.raw == my_idx.raw);
  assign holder_lower  = (holder.f.pos < my_idx.f.pos);
  assign holder_higher = (holder.f.pos > my_idx.f.pos);

  // token present and it carries our index
  assign is_mine = ext_next_cpu_q && same_idx;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      my_idx.raw <= '0;
    end else if (ctl_if.capture_index && !ctl_if.was_finished) begin
      // index as handed out by the bus at step 3
      my_idx.raw <= ext_cpu_index;
    end else if (ctl_if.seq_done) begin
      if (state == FINISH_END) begin
        // thread gone, back to inactive slot zero
        my_idx.raw <= '0;
      end else begin
        // mark active on thread start
        // a zero index goes active even with its own token in view
        if ((state == START_BEGIN) && (!is_mine || (my_idx.raw == '0))) begin
          my_idx.f.active <= 1'b1;
        end
        // renumber on other cores' messages
        if (!same_idx) begin
          if ((ext_cpu_msg_in == MSG_END) && holder.f.active && my_idx.f.active &&
              holder_lower) begin
            // a lower active core left
            my_idx.f.pos <= my_idx.f.pos - 31'd1;
          end else if ((ext_cpu_msg_in == MSG_START) && !holder.f.active) begin
            // an inactive core started
            if (my_idx.f.active) begin
              my_idx.f.pos <= my_idx.f.pos + 31'd1;
            end else begin
              my_idx.f.pos <= my_idx.f.pos - 31'd1;
            end
          end
        end
      end
    end
  end

  // holder position relative to ours
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ind_rel <= 2'b00;
    end else if (ctl_if.seq_done) begin
      if (ext_next_cpu_q) begin
        if (holder_lower) begin
          ind_rel <= 2'b01;
        end else if (holder_higher) begin
          ind_rel <= 2'b10;
        end else if (same_idx) begin
          ind_rel <= 2'b11;
        end
        // equal position, different flag keeps the old value
      end else if (pass_token) begin
        ind_rel <= 2'b00;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/token_controller.sv
`default_nettype none
`timescale 1ns/1ps

module token_controller #(
  parameter int addr_w              = 64,
  parameter int thread_header_space = 16
) (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  core_state_pkg::core_state_t state,
  input  logic                        read_q,
  input  logic                        write_q,
  input  logic                        bus_busy_in,
  input  logic                        is_mine,
  input  logic                        reset_msg,
  input  logic [addr_w-1:0]           addr_in,
  input  logic [addr_w-1:0]           data_in,
  output logic                        pass_token,
  output logic                        disp_online,
  output logic                        next_state,
  output logic                        ext_dispatcher_q,
  output logic                        bus_busy_out,
  output cpu_msg_pkg::cpu_msg_t       ext_cpu_msg,
  output logic [addr_w-1:0]           base_addr,
  output logic [addr_w-1:0]           base_addr_data,
  output logic                        ext_read_q,
  output logic                        ext_write_q,
  reset_ctl_if.ctl                    ctl_if
);
  import core_state_pkg::*;
  import cpu_msg_pkg::*;

  logic [addr_w-1:0] hdr_off;
  logic [addr_w-1:0] data_start;
  // step 3 seen, busy follows on step 4
  logic              capture_seen;
  // grant taken this edge
  logic              grant;
  // core states that leave the dispatcher request alone
  logic              disp_hold;

  assign hdr_off    = addr_w'(thread_header_space);
  // no data segment given, data sits with the code
  assign data_start = (data_in == '0) ? addr_in : data_in;
  assign grant      = ctl_if.seq_done && !bus_busy_in && is_mine;
  assign disp_hold  = (state == WAIT_FOR_START) || (state == START_BEGIN) ||
                      (state == FINISH_BEGIN) || (state == FINISH_END);

  // end of thread without a grant reruns the reset steps
  assign ctl_if.finish_restart = ctl_if.seq_done && !bus_busy_in && !is_mine &&
                                 (state == FINISH_END);

  // strobes reach the bus only while online, in the right state group
  assign ext_read_q  = disp_online && is_read_state(state) && read_q;
  assign ext_write_q = disp_online && is_write_state(state) && write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      capture_seen     <= 1'b0;
      bus_busy_out     <= 1'b0;
      pass_token       <= 1'b0;
      disp_online      <= 1'b0;
      next_state       <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      ext_cpu_msg      <= MSG_NONE;
      base_addr        <= '0;
      base_addr_data   <= '0;
    end else begin
      // pulses fall back after one cycle
      next_state   <= 1'b0;
      pass_token   <= 1'b0;
      ext_cpu_msg  <= MSG_NONE;
      capture_seen <= ctl_if.capture_index;
      bus_busy_out <= capture_seen;

      if (reset_msg) begin
        ext_cpu_msg <= MSG_RESET;
      end

      // token went out last cycle
      if (pass_token) begin
        disp_online <= 1'b0;
      end

      if (ctl_if.clear_online) begin
        disp_online      <= 1'b0;
        ext_dispatcher_q <= 1'b0;
      end else if (bus_busy_out) begin
        // step 5, ask for the dispatcher
        ext_dispatcher_q <= 1'b1;
      end

      if (ctl_if.seq_done && !bus_busy_in) begin
        // core went to the bus, hand the token on
        if (disp_online && (read_q || write_q)) begin
          pass_token <= 1'b1;
        end

        // dispatcher request follows the core's state group
        if (is_read_state(state, 1'b0) || is_write_state(state)) begin
          ext_dispatcher_q <= 1'b1;
        end else if (!disp_hold) begin
          ext_dispatcher_q <= 1'b0;
        end

        if (grant) begin
          disp_online <= 1'b1;
          if (state == WAIT_FOR_START) begin
            // thread start, bases skip the thread header
            ext_cpu_msg    <= MSG_START;
            base_addr      <= addr_in + hdr_off;
            base_addr_data <= data_start + hdr_off;
            next_state     <= 1'b1;
            pass_token     <= 1'b1;
          end else if (state == FINISH_BEGIN) begin
            // thread end
            ext_cpu_msg <= MSG_END;
            next_state  <= 1'b1;
            pass_token  <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/bridge_to_outside.sv
`default_nettype none
`timescale 1ns/1ps

module bridge_to_outside #(
  parameter int addr_w              = 64,
  parameter int thread_header_space = 16
) (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  core_state_pkg::core_state_t state,
  input  logic                        read_q,
  input  logic                        write_q,
  input  logic                        bus_busy_in,
  input  logic                        ext_next_cpu_q,
  input  logic [31:0]                 ext_cpu_index,
  input  cpu_msg_pkg::cpu_msg_t       ext_cpu_msg_in,
  input  logic [addr_w-1:0]           addr_in,
  input  logic [addr_w-1:0]           data_in,
  output logic [addr_w-1:0]           base_addr,
  output logic [addr_w-1:0]           base_addr_data,
  output logic [1:0]                  cpu_ind_rel,
  output logic                        bus_busy_out,
  output logic                        disp_online,
  output logic                        next_state,
  output logic                        rst,
  output logic                        ext_rst_e,
  output logic                        ext_next_cpu_e,
  output logic                        ext_dispatcher_q,
  output cpu_msg_pkg::cpu_msg_t       ext_cpu_msg,
  output logic                        ext_read_q,
  output logic                        ext_write_q
);

  // sequencer controls shared by tracker and token logic
  reset_ctl_if ctl_if ();

  // token carries our index
  logic is_mine;
  // step 3 reset message request
  logic reset_msg;

  reset_sequencer u_seq (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .state     (state),
    .rst       (rst),
    .ext_rst_e (ext_rst_e),
    .reset_msg (reset_msg),
    .ctl_if    (ctl_if.seq)
  );

  // token pass doubles as the tracker's clear for the relative index
  cpu_index_tracker u_tracker (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .ext_next_cpu_q (ext_next_cpu_q),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .pass_token     (ext_next_cpu_e),
    .ind_rel        (cpu_ind_rel),
    .is_mine        (is_mine),
    .ctl_if         (ctl_if.tracker)
  );

  token_controller #(
    .addr_w              (addr_w),
    .thread_header_space (thread_header_space)
  ) u_token (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .is_mine          (is_mine),
    .reset_msg        (reset_msg),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .pass_token       (ext_next_cpu_e),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .ext_dispatcher_q (ext_dispatcher_q),
    .bus_busy_out     (bus_busy_out),
    .ext_cpu_msg      (ext_cpu_msg),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ctl_if           (ctl_if.ctl)
  );

endmodule

`default_nettype wire

// File: tb/tb_bridge.sv
`default_nettype none
`timescale 1ns/1ps

module tb_bridge;
  import core_state_pkg::*;
  import cpu_msg_pkg::*;

  localparam int clk_period   = 20;
  localparam int header_space = 16;
  // scenario lengths in cycles for the watchdog
  localparam int gate_rounds  = 8;
  localparam int gate_len     = 6;
  localparam int run_cycles   = 10 + 10 + gate_rounds * (gate_len + 5) + 12 + 10 + 10;
  localparam int margin       = 50;

  logic              clk;
  logic              ext_rst_b;
  core_state_t       state;
  logic              read_q;
  logic              write_q;
  logic              bus_busy_in;
  logic              ext_next_cpu_q;
  logic [31:0]       ext_cpu_index;
  cpu_msg_t          ext_cpu_msg_in;
  logic [63:0]       addr_in;
  logic [63:0]       data_in;
  logic [63:0]       base_addr;
  logic [63:0]       base_addr_data;
  logic [1:0]        cpu_ind_rel;
  logic              bus_busy_out;
  logic              disp_online;
  logic              next_state;
  logic              rst;
  logic              ext_rst_e;
  logic              ext_next_cpu_e;
  logic              ext_dispatcher_q;
  cpu_msg_t          ext_cpu_msg;
  logic              ext_read_q;
  logic              ext_write_q;

  int                checks;
  int                errors;
  int                test_num;
  int                test_start_errors;
  logic              gate_chk_en;
  // this core's position as the bus should see it
  logic [30:0]       my_pos;
  // expected online flag and token pass
  logic              exp_online;
  logic              exp_pass;

  bridge_to_outside UUT (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .ext_cpu_msg_in   (ext_cpu_msg_in),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .cpu_ind_rel      (cpu_ind_rel),
    .bus_busy_out     (bus_busy_out),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .rst              (rst),
    .ext_rst_e        (ext_rst_e),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // code base in the high half and data base in the low half
  function automatic logic [127:0] ref_base(input logic [63:0] a, input logic [63:0] d);
    logic [63:0] code_b;
    logic [63:0] data_b;
    code_b = a + 64'(header_space);
    // empty data pointer means data follows the code
    data_b = (d == 64'd0) ? code_b : d + 64'(header_space);
    return {code_b, data_b};
  endfunction

  // any state except the ones that move the index or restart the sequence
  function automatic core_state_t random_state();
    core_state_t s;
    s = 6'($urandom % 22);
    if ((s == START_BEGIN) || (s == FINISH_END)) begin
      s = ALU_BEGIN;
    end
    return s;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name);
    int n;
    n = errors - test_start_errors;
    test_num++;
    if (n == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, n);
    end
    test_start_errors = errors;
  endtask

  // token shows for one cycle and returns after the edge that saw it
  task automatic send_token(input logic [31:0] idx, input core_state_t st);
    @(posedge clk);
    state          <= st;
    ext_next_cpu_q <= 1'b1;
    ext_cpu_index  <= idx;
    @(posedge clk);
    ext_next_cpu_q <= 1'b0;
    @(negedge clk);
  endtask

  // online flag and token pass from the grant and request rules
  always @(posedge clk) begin
    if (ext_rst_b) begin
      exp_online <= 1'b0;
      exp_pass   <= 1'b0;
    end else begin
      exp_pass <= 1'b0;
      // online ends on the edge after the token leaves
      if (exp_pass) begin
        exp_online <= 1'b0;
      end
      if (!bus_busy_in) begin
        // a core request while online hands the token on
        if (exp_online && (read_q || write_q)) begin
          exp_pass <= 1'b1;
        end
        // own token granted
        if (ext_next_cpu_q && (ext_cpu_index == {1'b0, my_pos})) begin
          exp_online <= 1'b1;
          if ((state == WAIT_FOR_START) || (state == FINISH_BEGIN)) begin
            exp_pass <= 1'b1;
          end
        end
      end
    end
  end

  // online flag, token pass and gated strobes every cycle once out of reset
  always @(negedge clk) begin
    if (gate_chk_en) begin
      check("disp_online", 64'(disp_online), 64'(exp_online));
      check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'(exp_pass));
      check("ext_read_q", 64'(ext_read_q),
            64'(exp_online && is_read_state(state) && read_q));
      check("ext_write_q", 64'(ext_write_q),
            64'(exp_online && is_write_state(state) && write_q));
    end
  end

  initial begin
    #((run_cycles + margin) * clk_period);
    $display("watchdog: run did not end within %0d cycles", run_cycles + margin);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [127:0] exp_base;
    logic [63:0]  a;
    logic [63:0]  d;
    logic [63:0]  prev_base;
    logic [63:0]  prev_data;
    logic [30:0]  old_pos;
    void'($urandom(39));
    checks            = 0;
    errors            = 0;
    test_num          = 0;
    test_start_errors = 0;
    gate_chk_en       = 1'b0;
    my_pos            = 31'(20 + $urandom % 200);
    ext_rst_b         = 1'b1;
    state             = WAIT_FOR_START;
    read_q            = 1'b0;
    write_q           = 1'b0;
    bus_busy_in       = 1'b0;
    ext_next_cpu_q    = 1'b0;
    // index is on the bus before capture
    ext_cpu_index     = {1'b0, my_pos};
    ext_cpu_msg_in    = MSG_NONE;
    addr_in           = 64'd0;
    data_in           = 64'd0;

    // reset and then the five-step sequence
    @(posedge clk);
    @(negedge clk);
    check("base_addr", base_addr, 64'd0);
    check("base_addr_data", base_addr_data, 64'd0);
    check("control outputs", 64'({rst, ext_rst_e, disp_online, next_state, ext_next_cpu_e,
          ext_dispatcher_q, bus_busy_out, cpu_ind_rel, ext_cpu_msg}), 64'd0);
    @(posedge clk);
    ext_rst_b <= 1'b0;
    gate_chk_en = 1'b1;
    for (int k = 1; k <= 6; k++) begin
      @(posedge clk);
      @(negedge clk);
      check("ext_cpu_msg", 64'(ext_cpu_msg), 64'((k == 3) ? MSG_RESET : MSG_NONE));
      check("rst", 64'(rst), 64'(k == 4));
      check("ext_rst_e", 64'(ext_rst_e), 64'(k == 4));
      check("bus_busy_out", 64'(bus_busy_out), 64'(k == 4));
      check("ext_dispatcher_q", 64'(ext_dispatcher_q), 64'(k >= 5));
    end
    report_test("reset sequence");

    // thread start with no data pointer in the second round
    for (int r = 0; r < 2; r++) begin
      a = {$urandom, $urandom};
      d = (r == 1) ? 64'd0 : {$urandom, $urandom};
      exp_base = ref_base(a, d);
      @(posedge clk);
      addr_in <= a;
      data_in <= d;
      send_token({1'b0, my_pos}, WAIT_FOR_START);
      check("ext_cpu_msg", 64'(ext_cpu_msg), 64'(MSG_START));
      check("base_addr", base_addr, exp_base[127:64]);
      check("base_addr_data", base_addr_data, exp_base[63:0]);
      check("next_state", 64'(next_state), 64'd1);
      check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd1);
      check("disp_online", 64'(disp_online), 64'd1);
      @(posedge clk);
      @(negedge clk);
      check("next_state", 64'(next_state), 64'd0);
      check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
      check("ext_cpu_msg", 64'(ext_cpu_msg), 64'(MSG_NONE));
      check("disp_online", 64'(disp_online), 64'd0);
    end
    report_test("thread start");

    // go online in a bus state and then drive random states and strobes
    for (int r = 0; r < gate_rounds; r++) begin
      send_token({1'b0, my_pos}, (r % 2 == 0) ? READ_SRC0 : WRITE_DST);
      check("disp_online", 64'(disp_online), 64'd1);
      check("ext_dispatcher_q", 64'(ext_dispatcher_q), 64'd1);
      for (int k = 0; k < gate_len; k++) begin
        @(posedge clk);
        state   <= random_state();
        read_q  <= 1'($urandom % 2);
        write_q <= 1'($urandom % 2);
      end
      // a read request hands the token on and drops online
      @(posedge clk);
      state   <= START_READ_CMD;
      read_q  <= 1'b1;
      write_q <= 1'b0;
      repeat (2) @(posedge clk);
      read_q <= 1'b0;
      state  <= ALU_BEGIN;
      @(negedge clk);
      check("disp_online", 64'(disp_online), 64'd0);
    end
    report_test("request gating");

    // holder below and above and then the same word under back-pressure
    send_token({1'($urandom % 2), 31'($urandom % my_pos)}, ALU_BEGIN);
    check("cpu_ind_rel", 64'(cpu_ind_rel), 64'h1);
    send_token({1'($urandom % 2), my_pos + 31'd1 + 31'($urandom % 100)}, ALU_BEGIN);
    check("cpu_ind_rel", 64'(cpu_ind_rel), 64'h2);
    @(posedge clk);
    bus_busy_in <= 1'b1;
    send_token({1'b0, my_pos}, ALU_BEGIN);
    check("cpu_ind_rel", 64'(cpu_ind_rel), 64'h3);
    check("disp_online", 64'(disp_online), 64'd0);
    @(posedge clk);
    bus_busy_in <= 1'b0;
    report_test("relative index");

    // an inactive core starts so this inactive core moves down one
    @(posedge clk);
    ext_cpu_msg_in <= MSG_START;
    ext_cpu_index  <= {1'b0, my_pos + 31'd40};
    @(posedge clk);
    ext_cpu_msg_in <= MSG_NONE;
    old_pos = my_pos;
    my_pos  = my_pos - 31'd1;
    send_token({1'b0, old_pos}, WAIT_FOR_START);
    check("disp_online", 64'(disp_online), 64'd0);
    check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
    send_token({1'b0, my_pos}, WAIT_FOR_START);
    check("disp_online", 64'(disp_online), 64'd1);
    @(posedge clk);
    @(negedge clk);
    report_test("renumbering");

    // busy bus ignores our token
    prev_base = base_addr;
    prev_data = base_addr_data;
    @(posedge clk);
    bus_busy_in <= 1'b1;
    addr_in     <= {$urandom, $urandom};
    data_in     <= {$urandom, $urandom};
    send_token({1'b0, my_pos}, WAIT_FOR_START);
    check("disp_online", 64'(disp_online), 64'd0);
    check("next_state", 64'(next_state), 64'd0);
    check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd0);
    check("ext_cpu_msg", 64'(ext_cpu_msg), 64'(MSG_NONE));
    check("base_addr", base_addr, prev_base);
    check("base_addr_data", base_addr_data, prev_data);
    @(posedge clk);
    bus_busy_in <= 1'b0;
    // thread end
    send_token({1'b0, my_pos}, FINISH_BEGIN);
    check("ext_cpu_msg", 64'(ext_cpu_msg), 64'(MSG_END));
    check("next_state", 64'(next_state), 64'd1);
    check("ext_next_cpu_e", 64'(ext_next_cpu_e), 64'd1);
    check("disp_online", 64'(disp_online), 64'd1);
    @(posedge clk);
    state <= ALU_BEGIN;
    @(negedge clk);
    check("next_state", 64'(next_state), 64'd0);
    check("ext_cpu_msg", 64'(ext_cpu_msg), 64'(MSG_NONE));
    report_test("back-pressure and thread end");

    $display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
design/core_state_pkg.sv
design/cpu_msg_pkg.sv
design/reset_ctl_if.sv
design/reset_sequencer.sv
design/cpu_index_tracker.sv
design/token_controller.sv
design/bridge_to_outside.sv
tb/tb_bridge.sv

// File: Makefile
# verilator build of the bridge testbench

VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_bridge
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
